//--- alpha_startup.f
common/alpha_pkg.sv
common/phase_timer_if.sv
hdl/start_edge_detect.sv
sequencer/phase_timer.sv
sequencer/startup_sequencer.sv
hdl/word_deserializer.sv
hdl/alpha_startup.sv
bench/alpha_startup_checks.sv
bench/alpha_startup_tb.sv

//--- bench/alpha_startup_checks.sv
module alpha_startup_checks (
	input logic clock,
	input logic reset,
	input logic start_button,
	input logic serial_bit,
	input logic dreset,
	input logic sync,
	input logic tok_a_f2t,
	input logic sequence_active,
	input logic [alpha_pkg::word_bits-1:0] word,
	input logic word_ready,
	input int test_id // test now running, 0 during reset, 6 when done
);
	import alpha_pkg::*;

	localparam int seq_len = lead_cycles + 3 * pulse_cycles + 3 * gap_cycles;
	localparam int sync_start = lead_cycles + pulse_cycles + gap_cycles; // counted from lead entry
	localparam int tok_start = sync_start + pulse_cycles + gap_cycles;

	int pass_count [0:6];
	int fail_count [0:6];

	// start model
	logic [7:0] button_hist; // sampled button, newest in bit 0
	logic seq_start; // lead is entered on this edge
	logic model_active;
	int seq_count; // cycles since lead entry
	logic exp_active;
	logic exp_dreset;
	logic exp_sync;
	logic exp_tok;

	// deserializer model
	logic [word_bits-1:0] bit_hist; // newest in bit 0
	logic [word_bits-1:0] next_hist;
	int bits_seen;
	logic word_done; // this edge takes the tenth bit of a word
	logic [word_bits-1:0] exp_word;
	logic exp_ready;

	initial begin
		for (int i = 0; i <= 6; i++) begin
			pass_count[i] = 0;
			fail_count[i] = 0;
		end
	end

	function automatic string test_title(input int id);
		case (id)
			1: return "reset state";
			2: return "sequence shape";
			3: return "edge only";
			4: return "restart";
			5: return "deserializer words";
			default: return "between tests";
		endcase
	endfunction

	function automatic logic in_pulse(input int count, input int first);
		return (count >= first) && (count < first + pulse_cycles);
	endfunction

	// history holds the newest bit at the bottom, the word wants the earliest there
	function automatic logic [word_bits-1:0] oldest_first(input logic [word_bits-1:0] hist);
		logic [word_bits-1:0] flipped;
		for (int i = 0; i < word_bits; i++) begin
			flipped[i] = hist[word_bits-1-i];
		end
		return flipped;
	endfunction

	task automatic note_pass();
		pass_count[test_id]++;
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		fail_count[test_id]++;
		$display("[ERROR] %s: %s expected %0h actual %0h", test_title(test_id), what,
			expected, actual);
	endtask

	task automatic report_event(input string what);
		fail_count[test_id]++;
		$display("test %s failed: %s", test_title(test_id), what);
	endtask

	// press seen 7 edges back: pipeline, pulse register, then lead
	assign seq_start = button_hist[6] && !button_hist[7];
	assign exp_active = model_active;
	assign exp_dreset = model_active && in_pulse(seq_count, lead_cycles);
	assign exp_sync = model_active && in_pulse(seq_count, sync_start);
	assign exp_tok = model_active && in_pulse(seq_count, tok_start);

	always_ff @(posedge clock) begin
		if (reset) begin
			button_hist <= '0;
			model_active <= 1'b0;
			seq_count <= 0;
		end else begin
			button_hist <= {button_hist[6:0], start_button};
			if (seq_start) begin
				model_active <= 1'b1; // also a restart mid-sequence
				seq_count <= 0;
			end else if (model_active) begin
				if (seq_count == seq_len - 1) model_active <= 1'b0; // tail done
				seq_count <= seq_count + 1;
			end
		end
	end

	assign next_hist = {bit_hist[word_bits-2:0], serial_bit};
	assign word_done = ((bits_seen + 1) % word_bits) == 0;

	always_ff @(posedge clock) begin
		if (reset) begin
			bit_hist <= '0;
			bits_seen <= 0; // first bit comes on the first edge out of reset
			exp_word <= '0;
			exp_ready <= 1'b0;
		end else begin
			bit_hist <= next_hist;
			bits_seen <= bits_seen + 1;
			exp_ready <= word_done;
			if (word_done) exp_word <= oldest_first(next_hist);
		end
	end

	a_active: assert property (@(posedge clock) disable iff (reset) sequence_active == exp_active)
		note_pass();
		else report_mismatch("sequence_active", 32'($sampled(exp_active)),
			32'($sampled(sequence_active)));

	a_dreset: assert property (@(posedge clock) disable iff (reset) dreset == exp_dreset)
		note_pass();
		else report_mismatch("dreset", 32'($sampled(exp_dreset)), 32'($sampled(dreset)));

	a_sync: assert property (@(posedge clock) disable iff (reset) sync == exp_sync)
		note_pass();
		else report_mismatch("sync", 32'($sampled(exp_sync)), 32'($sampled(sync)));

	a_tok: assert property (@(posedge clock) disable iff (reset) tok_a_f2t == exp_tok)
		note_pass();
		else report_mismatch("tok_a_f2t", 32'($sampled(exp_tok)), 32'($sampled(tok_a_f2t)));

	a_ready: assert property (@(posedge clock) disable iff (reset) word_ready == exp_ready)
		note_pass();
		else report_mismatch("word_ready", 32'($sampled(exp_ready)), 32'($sampled(word_ready)));

	a_word: assert property (@(posedge clock) disable iff (reset) word == exp_word)
		note_pass();
		else report_mismatch("word", 32'($sampled(exp_word)), 32'($sampled(word)));

	// press from idle shows up as a rise 8 sampled edges later
	a_start_delay: assert property (@(posedge clock) disable iff (reset)
		$rose(start_button) && !sequence_active |-> ##8 $rose(sequence_active))
		note_pass();
		else report_event("sequence_active did not rise 8 cycles after the press");

	a_dreset_width: assert property (@(posedge clock) disable iff (reset)
		$rose(dreset) |-> ##pulse_cycles $fell(dreset))
		note_pass();
		else report_event("dreset pulse was not 10 cycles wide");

	a_word_spacing: assert property (@(posedge clock) disable iff (reset)
		word_ready |-> ##word_bits word_ready)
		note_pass();
		else report_event("next word_ready did not come 10 cycles after the last one");

endmodule

//--- bench/alpha_startup_tb.sv
module alpha_startup_tb;
	import alpha_pkg::*;

	localparam int seq_len = lead_cycles + 3 * pulse_cycles + 3 * gap_cycles;
	localparam int reset_cycles = 16;
	localparam int idle_cycles = 30;
	localparam int hold_cycles = 200;
	localparam int serial_cycles = 200;
	// budget per test in cycles, summed for the watchdog
	localparam int run_cycles = reset_cycles + idle_cycles + (seq_len + 60)
		+ (hold_cycles + 60) + (2 * seq_len + 80) + (serial_cycles + 30);
	localparam int watchdog_cycles = run_cycles + 200;

	localparam int line_active = 0;
	localparam int line_sync = 1;

	logic clock;
	logic reset;
	logic start_button;
	logic serial_bit;
	logic dreset;
	logic sync;
	logic tok_a_f2t;
	logic sequence_active;
	logic [word_bits-1:0] word;
	logic word_ready;

	int test_id;
	int test_timeouts; // waits given up in the running test
	int timeouts;
	logic [31:0] lfsr_state;

	alpha_startup u_dut (
		.clock (clock),
		.reset (reset),
		.start_button (start_button),
		.serial_bit (serial_bit),
		.dreset (dreset),
		.sync (sync),
		.tok_a_f2t (tok_a_f2t),
		.sequence_active (sequence_active),
		.word (word),
		.word_ready (word_ready)
	);

	alpha_startup_checks u_checks (
		.clock (clock),
		.reset (reset),
		.start_button (start_button),
		.serial_bit (serial_bit),
		.dreset (dreset),
		.sync (sync),
		.tok_a_f2t (tok_a_f2t),
		.sequence_active (sequence_active),
		.word (word),
		.word_ready (word_ready),
		.test_id (test_id)
	);

	always #10 clock = ~clock; // period 20

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	function automatic logic line_value(input int which);
		if (which == line_sync) return sync;
		return sequence_active;
	endfunction

	// inputs change and outputs are read 2 units past the edge
	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	task automatic press_button(input int cycles);
		start_button = 1'b1;
		repeat (cycles) next_cycle();
		start_button = 1'b0;
	endtask

	task automatic wait_for_line(input int which, input logic level, input int limit,
		input string what);
		int waited;
		waited = 0;
		while (line_value(which) !== level && waited < limit) begin
			next_cycle();
			waited++;
		end
		if (line_value(which) !== level) begin
			$display("test %0d: gave up after %0d cycles waiting for %s", test_id, limit, what);
			test_timeouts++;
			timeouts++;
		end
	endtask

	task automatic begin_test(input int id);
		test_id = id;
		test_timeouts = 0;
	endtask

	task automatic finish_test(input int id);
		$display("test %0d %s: %0d checks passed, %0d failed, %0d timeouts", id,
			u_checks.test_title(id), u_checks.pass_count[id], u_checks.fail_count[id],
			test_timeouts);
	endtask

	initial begin
		int passed;
		int failed;
		clock = 1'b0;
		reset = 1'b1;
		start_button = 1'b0;
		serial_bit = 1'b0;
		test_id = 0;
		test_timeouts = 0;
		timeouts = 0;
		lfsr_state = 32'd32508;
		repeat (reset_cycles) @(posedge clock);
		#2;
		reset = 1'b0;

		begin_test(1); // no press, all quiet
		repeat (idle_cycles) next_cycle();
		finish_test(1);

		begin_test(2);
		press_button(3); // short press
		wait_for_line(line_active, 1'b1, 20, "sequence_active to rise");
		wait_for_line(line_active, 1'b0, seq_len + 10, "sequence_active to fall");
		repeat (20) next_cycle();
		finish_test(2);

		begin_test(3);
		press_button(hold_cycles); // sequence ends while still held
		wait_for_line(line_active, 1'b0, 20, "sequence_active to stay low");
		repeat (20) next_cycle();
		finish_test(3);

		begin_test(4);
		press_button(3);
		wait_for_line(line_sync, 1'b1, seq_len, "sync to rise");
		press_button(3); // lands while sync is high
		wait_for_line(line_active, 1'b0, seq_len + 20, "the restarted sequence to end");
		repeat (20) next_cycle();
		finish_test(4);

		begin_test(5);
		repeat (serial_cycles) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			serial_bit = lfsr_state[0];
			next_cycle();
		end
		serial_bit = 1'b0;
		repeat (word_bits + 2) next_cycle();
		finish_test(5);
		test_id = 6;

		passed = 0;
		failed = 0;
		for (int i = 0; i <= 6; i++) begin
			passed += u_checks.pass_count[i];
			failed += u_checks.fail_count[i];
		end
		$display("all tests: %0d checks passed, %0d failed, %0d timeouts", passed, failed,
			timeouts);
		if (failed == 0 && timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// hard stop if a wait never returns
	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("watchdog: run did not end within %0d cycles", watchdog_cycles);
		$display("Something failed");
		$finish;
	end

endmodule

//--- common/alpha_pkg.sv
package alpha_pkg;

	// start button front end
	localparam int button_pipe_depth = 7; // sampling stages, edge taken from the top two

	// startup sequence timing, all in clock cycles
	localparam int lead_cycles = 11; // sequence start to dreset rise
	localparam int pulse_cycles = 10; // high time of dreset, sync, tok_a_f2t
	localparam int gap_cycles = 10; // low time between pulses, also the tail

	// longest phase has to fit the timer
	localparam int timer_width = 4;

	// serial return path
	localparam int word_bits = 10; // chip sends 10-bit words
	localparam int bit_count_width = 4; // counts 0 .. word_bits-1

	// sequencer phases in the order they are walked
	typedef enum logic [2:0] {
		idle, // lines low, waiting for a start pulse
		lead, // settle time before dreset
		dreset_high,
		gap_sync,
		sync_high,
		gap_tok,
		tok_high,
		tail // last gap, sequence_active still high
	} seq_phase_t;

endpackage

//--- common/phase_timer_if.sv
interface phase_timer_if;
	import alpha_pkg::*;

	logic load; // start timing a new phase
	logic [timer_width-1:0] duration; // phase length, taken with load
	logic expired; // last cycle of the phase
	logic running; // a phase is being timed

	// state machine side
	modport sequencer (
		output load,
		output duration,
		input expired,
		input running
	);

	// counter side
	modport timer (
		input load,
		input duration,
		output expired,
		output running
	);

endinterface

//--- hdl/alpha_startup.sv
module alpha_startup (
	input logic clock,
	input logic reset,
	input logic start_button,
	input logic serial_bit, // data back from the chip
	output logic dreset,
	output logic sync,
	output logic tok_a_f2t,
	output logic sequence_active,
	output logic [alpha_pkg::word_bits-1:0] word,
	output logic word_ready
);

	logic start_pulse; // one cycle per button press

	phase_timer_if tmr_if ();

	// button front end
	start_edge_detect u_start_edge_detect (
		.clock (clock),
		.reset (reset),
		.button (start_button),
		.start_pulse (start_pulse)
	);

	// control line sequence
	startup_sequencer u_startup_sequencer (
		.clock (clock),
		.reset (reset),
		.start_pulse (start_pulse),
		.tmr (tmr_if.sequencer),
		.dreset (dreset),
		.sync (sync),
		.tok_a_f2t (tok_a_f2t),
		.sequence_active (sequence_active)
	);

	phase_timer u_phase_timer (
		.clock (clock),
		.reset (reset),
		.tmr (tmr_if.timer)
	);

	// return path, independent of the sequence
	word_deserializer u_word_deserializer (
		.clock (clock),
		.reset (reset),
		.serial_bit (serial_bit),
		.word (word),
		.word_ready (word_ready)
	);

endmodule

//--- hdl/start_edge_detect.sv
module start_edge_detect (
	input logic clock,
	input logic reset,
	input logic button, // raw, asynchronous to clock
	output logic start_pulse
);
	import alpha_pkg::*;

	// button samples, newest in bit 0
	logic [button_pipe_depth-1:0] button_pipe;
	logic rising; // low-to-high step between the two oldest samples

	// first stages double as a crude synchronizer
	assign rising = (button_pipe[button_pipe_depth-1:button_pipe_depth-2] == 2'b01);

	always_ff @(posedge clock) begin
		if (reset) begin
			button_pipe <= '0;
			start_pulse <= 1'b0;
		end else begin
			button_pipe <= {button_pipe[button_pipe_depth-2:0], button};
			start_pulse <= rising; // one cycle only, held button gives one pulse
		end
	end

endmodule

//--- hdl/word_deserializer.sv
module word_deserializer (
	input logic clock,
	input logic reset,
	input logic serial_bit,
	output logic [alpha_pkg::word_bits-1:0] word,
	output logic word_ready
);
	import alpha_pkg::*;

	logic [word_bits-2:0] shifter; // earliest bit drifts down to bit 0
	logic [bit_count_width-1:0] bit_count; // bits taken into the current word
	logic last_bit; // this edge samples the tenth bit

	assign last_bit = (bit_count == bit_count_width'(word_bits - 1));

	// one bit per clock with the lsb first on the line
	always_ff @(posedge clock) begin
		shifter <= {serial_bit, shifter[word_bits-2:1]};
	end

	// word alignment is fixed by reset
	always_ff @(posedge clock) begin
		if (reset) begin
			bit_count <= '0;
			word <= '0;
			word_ready <= 1'b0;
		end else begin
			word_ready <= 1'b0;
			if (last_bit) begin
				bit_count <= '0;
				word <= {serial_bit, shifter}; // includes the bit on the line now
				word_ready <= 1'b1;
			end else begin
				bit_count <= bit_count + 1'b1;
			end
		end
	end

	// strobes come a full word apart
	a_strobe_spacing: assert property (@(posedge clock) disable iff (reset)
		word_ready |=> (!word_ready) [* word_bits-1])
		else $error("word_ready strobes closer than one word");

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the alpha_startup testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module alpha_startup_tb \
	-f alpha_startup.f \
	-o alpha_startup_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/alpha_startup_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Everything OK" "$log"; then
	exit 0
fi
echo "pass line not found in $log"
exit 1

//--- sequencer/phase_timer.sv
module phase_timer (
	input logic clock,
	input logic reset,
	phase_timer_if.timer tmr
);
	import alpha_pkg::*;

	logic [timer_width-1:0] count; // cycles left in the phase, 0 on the last one

	// load of duration D gives expired on the D-th cycle after the load edge
	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
			tmr.running <= 1'b0;
			tmr.expired <= 1'b0;
		end else if (tmr.load) begin
			// also a restart when already running
			count <= tmr.duration - 1'b1;
			tmr.running <= (tmr.duration != '0);
			tmr.expired <= (tmr.duration == timer_width'(1)); // one-cycle phase
		end else if (tmr.running) begin
			if (count == '0) begin
				tmr.running <= 1'b0; // phase over, nobody reloaded
				tmr.expired <= 1'b0;
			end else begin
				count <= count - 1'b1;
				tmr.expired <= (count == timer_width'(1)); // next value is the last
			end
		end
	end

	// expired has to sit inside a timed phase
	a_expired_running: assert property (@(posedge clock) disable iff (reset)
		tmr.expired |-> tmr.running)
		else $error("phase timer expired while not running");

endmodule

//--- sequencer/startup_sequencer.sv
module startup_sequencer (
	input logic clock,
	input logic reset,
	input logic start_pulse,
	phase_timer_if.sequencer tmr,
	output logic dreset,
	output logic sync,
	output logic tok_a_f2t,
	output logic sequence_active
);
	import alpha_pkg::*;

	seq_phase_t phase; // phase we are in now
	seq_phase_t next_phase; // phase entered on the coming edge

	// phase walk, a start pulse always wins
	always_comb begin
		next_phase = phase;
		if (start_pulse) begin
			next_phase = lead; // restart from the top, also mid-sequence
		end else if (tmr.expired) begin
			case (phase)
				lead: next_phase = dreset_high;
				dreset_high: next_phase = gap_sync;
				gap_sync: next_phase = sync_high;
				sync_high: next_phase = gap_tok;
				gap_tok: next_phase = tok_high;
				tok_high: next_phase = tail;
				tail: next_phase = idle; // done
				default: next_phase = idle;
			endcase
		end else if (phase != idle && !tmr.running) begin
			next_phase = idle; // timer dropped out under us, give up the sequence
		end
	end

	// new phase gets its length on the entry edge
	// load can land on the expired cycle, so phases chain with no dead cycle
	assign tmr.load = (next_phase != idle) && (start_pulse || tmr.expired);

	always_comb begin
		case (next_phase)
			lead: tmr.duration = timer_width'(lead_cycles);
			dreset_high,
			sync_high,
			tok_high: tmr.duration = timer_width'(pulse_cycles);
			gap_sync,
			gap_tok,
			tail: tmr.duration = timer_width'(gap_cycles);
			default: tmr.duration = '0; // idle, not loaded
		endcase
	end

	// outputs follow the phase being entered, so they switch on the same edge
	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= idle;
			dreset <= 1'b0;
			sync <= 1'b0;
			tok_a_f2t <= 1'b0;
			sequence_active <= 1'b0;
		end else begin
			phase <= next_phase;
			dreset <= (next_phase == dreset_high);
			sync <= (next_phase == sync_high);
			tok_a_f2t <= (next_phase == tok_high);
			sequence_active <= (next_phase != idle);
		end
	end

	// chip must never see two control lines up together
	a_one_line_high: assert property (@(posedge clock) disable iff (reset)
		$onehot0({dreset, sync, tok_a_f2t}))
		else $error("more than one control line high");

endmodule
